// ==== common/riscv_block_pkg.sv ====
package riscv_block_pkg;

  // Core data port
  localparam int DATA_WIDTH      = 32;
  localparam int STRB_WIDTH      = DATA_WIDTH / 8;
  localparam int CORE_ADDR_WIDTH = 24;

  // Data memory, 4 KiB of 32-bit words
  localparam int DMEM_WORDS      = 1024;
  localparam int DMEM_ADDR_WIDTH = 10;

  // Broadcast region sits in the top words of the data memory
  localparam int BC_REGION_WORDS = 64;
  localparam int MSG_ADDR_WIDTH  = 6;
  localparam int BC_BASE_WORD    = DMEM_WORDS - BC_REGION_WORDS;

  localparam int CORE_ID_WIDTH   = 4;

  // Message layout: data, strobe, region word offset, sender core id
  localparam int MSG_STRB_LSB    = DATA_WIDTH;
  localparam int MSG_OFFSET_LSB  = MSG_STRB_LSB + STRB_WIDTH;
  localparam int MSG_CORE_ID_LSB = MSG_OFFSET_LSB + MSG_ADDR_WIDTH;
  localparam int MSG_WIDTH       = MSG_CORE_ID_LSB + CORE_ID_WIDTH;

  // Outgoing credit pool
  localparam int BC_CREDITS      = 4;
  localparam int CREDIT_WIDTH    = 3;

  // Status channels
  localparam int STATUS_WIDTH    = 32;
  localparam int ERR_COUNT_WIDTH = 16;

  typedef enum logic [1:0] {
    REGION_DMEM,
    REGION_BC,
    REGION_INVALID
  } mem_region_e;

  typedef enum logic [1:0] {
    STAT_CORE_ID   = 2'd0,
    STAT_BC_ENABLE = 2'd1,
    STAT_RSVD_2    = 2'd2,
    STAT_RSVD_3    = 2'd3
  } status_addr_e;

endpackage

// ==== common/core_mem_if.sv ====
// One decoded core access, one cycle after acceptance
interface core_mem_if
  import riscv_block_pkg::*;
();

  logic                       req_valid;
  logic                       wen;
  logic [STRB_WIDTH-1:0]      strb;
  logic [DMEM_ADDR_WIDTH-1:0] word_addr;
  logic [DATA_WIDTH-1:0]      wr_data;
  mem_region_e                region;

  modport src (
    output req_valid,
    output wen,
    output strb,
    output word_addr,
    output wr_data,
    output region
  );

  modport dst (
    input  req_valid,
    input  wen,
    input  strb,
    input  word_addr,
    input  wr_data,
    input  region
  );

endinterface

// ==== common/bc_msg_if.sv ====
// Outgoing broadcast message with its credit return
interface bc_msg_if
  import riscv_block_pkg::*;
();

  logic                    msg_valid;
  logic [MSG_WIDTH-1:0]    msg;
  logic                    credit;
  logic [CREDIT_WIDTH-1:0] credits_free;

  modport gen (
    output msg_valid,
    output msg,
    output credits_free,
    input  credit
  );

  modport top (
    input  msg_valid,
    input  msg,
    input  credits_free,
    output credit
  );

endinterface

// ==== verilog/status_regs.sv ====
module status_regs
  import riscv_block_pkg::*;
(
  input  logic                       clk,
  input  logic                       core_rst,

  // Configuration writes from the wrapper
  input  logic [STATUS_WIDTH-1:0]    wrapper_status_data,
  input  logic [1:0]                 wrapper_status_addr,
  input  logic                       wrapper_status_valid,

  // Events to report
  input  logic                       decode_error,
  input  logic [CREDIT_WIDTH-1:0]    credits_free,

  output logic [CORE_ID_WIDTH-1:0]   core_id,
  output logic                       bc_enable,
  output logic [STATUS_WIDTH-1:0]    core_status_data,
  output logic [1:0]                 core_status_addr
);

  logic [ERR_COUNT_WIDTH-1:0] err_count;
  status_addr_e               wr_sel;

  assign wr_sel = status_addr_e'(wrapper_status_addr);

  ////////////////////////////////////////////////////////////////////////////
  // Wrapper writes
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (core_rst) begin
      core_id   <= '0;
      bc_enable <= 1'b1;
    end else if (wrapper_status_valid) begin
      case (wr_sel)
        STAT_CORE_ID:   core_id   <= wrapper_status_data[CORE_ID_WIDTH-1:0];
        STAT_BC_ENABLE: bc_enable <= wrapper_status_data[0];
        // Reserved codes are ignored
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Error count and status word
  ////////////////////////////////////////////////////////////////////////////

  // Saturates at all ones
  always_ff @(posedge clk) begin
    if (core_rst) begin
      err_count <= '0;
    end else if (decode_error && (err_count != '1)) begin
      err_count <= err_count + 1'b1;
    end
  end

  assign core_status_data = {{(STATUS_WIDTH-ERR_COUNT_WIDTH-CREDIT_WIDTH){1'b0}},
                             credits_free, err_count};
  assign core_status_addr = STAT_CORE_ID;

endmodule

// ==== mem_sys/addr_decode.sv ====
module addr_decode
  import riscv_block_pkg::*;
(
  input  logic                       clk,
  input  logic                       core_rst,

  input  logic                       core_mem_en,
  input  logic                       core_mem_wen,
  input  logic [STRB_WIDTH-1:0]      core_mem_strb,
  input  logic [CORE_ADDR_WIDTH-1:0] core_mem_addr,
  input  logic [DATA_WIDTH-1:0]      core_mem_wr_data,
  input  logic [CREDIT_WIDTH-1:0]    credits_free,
  input  logic                       bc_enable,

  output logic                       core_mem_ready,
  output logic                       decode_error,

  core_mem_if.src                    req
);

  logic                       accept;
  logic                       bc_in_stage;
  logic                       bc_out_q;
  logic [DMEM_ADDR_WIDTH-1:0] word_addr_d;
  mem_region_e                region_d;

  // A broadcast store blocks new requests until its message has left
  assign bc_in_stage    = req.req_valid && req.wen && (req.region == REGION_BC);
  assign core_mem_ready = (credits_free != '0) && !bc_in_stage && !bc_out_q;
  assign accept         = core_mem_en && core_mem_ready;

  assign word_addr_d = core_mem_addr[DMEM_ADDR_WIDTH+1:2];

  always_comb begin
    if (|core_mem_addr[CORE_ADDR_WIDTH-1:DMEM_ADDR_WIDTH+2]) begin
      region_d = REGION_INVALID;
    end else if ((word_addr_d >= DMEM_ADDR_WIDTH'(BC_BASE_WORD)) &&
                 (bc_enable || !core_mem_wen)) begin
      region_d = REGION_BC;
    end else begin
      // Also covers broadcast-region stores while broadcasting is off
      region_d = REGION_DMEM;
    end
  end

  always_ff @(posedge clk) begin
    if (core_rst) begin
      req.req_valid <= 1'b0;
      bc_out_q      <= 1'b0;
    end else begin
      req.req_valid <= accept;
      bc_out_q      <= bc_in_stage;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req.wen       <= core_mem_wen;
      req.strb      <= core_mem_strb;
      req.word_addr <= word_addr_d;
      req.wr_data   <= core_mem_wr_data;
      req.region    <= region_d;
    end
  end

  // One cycle per invalid access
  assign decode_error = req.req_valid && (req.region == REGION_INVALID);

endmodule

// ==== mem_sys/dmem_bank.sv ====
module dmem_bank
  import riscv_block_pkg::*;
(
  input  logic                  clk,
  input  logic                  core_rst,

  // Messages from other cores
  input  logic [MSG_WIDTH-1:0]  bc_msg_in,
  input  logic                  bc_msg_in_valid,

  output logic [DATA_WIDTH-1:0] core_mem_rd_data,
  output logic                  core_mem_rd_valid,

  core_mem_if.dst               req
);

  logic [DATA_WIDTH-1:0]      mem [DMEM_WORDS];

  logic                       core_wr;
  logic                       core_rd;
  logic [DMEM_ADDR_WIDTH-1:0] in_word_addr;
  logic [DATA_WIDTH-1:0]      in_data;
  logic [STRB_WIDTH-1:0]      in_strb;
  logic [MSG_ADDR_WIDTH-1:0]  in_offset;
  logic                       collide;

  assign in_data   = bc_msg_in[DATA_WIDTH-1:0];
  assign in_strb   = bc_msg_in[MSG_OFFSET_LSB-1:MSG_STRB_LSB];
  assign in_offset = bc_msg_in[MSG_CORE_ID_LSB-1:MSG_OFFSET_LSB];

  assign in_word_addr = DMEM_ADDR_WIDTH'(BC_BASE_WORD) + DMEM_ADDR_WIDTH'(in_offset);

  // Incoming message takes the whole word on a same-address clash
  assign collide = bc_msg_in_valid && (in_word_addr == req.word_addr);
  assign core_wr = req.req_valid && req.wen && (req.region != REGION_INVALID) && !collide;
  assign core_rd = req.req_valid && !req.wen;

  ////////////////////////////////////////////////////////////////////////////
  // Write ports
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    for (int i = 0; i < STRB_WIDTH; i++) begin
      if (core_wr && req.strb[i]) begin
        mem[req.word_addr][8*i +: 8] <= req.wr_data[8*i +: 8];
      end
      if (bc_msg_in_valid && in_strb[i]) begin
        mem[in_word_addr][8*i +: 8] <= in_data[8*i +: 8];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Core read port
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (core_rst) begin
      core_mem_rd_valid <= 1'b0;
    end else begin
      core_mem_rd_valid <= core_rd;
    end
  end

  // Outside the memory the load still completes, with zero data
  always_ff @(posedge clk) begin
    if (core_rd) begin
      if (req.region == REGION_INVALID) begin
        core_mem_rd_data <= '0;
      end else begin
        core_mem_rd_data <= mem[req.word_addr];
      end
    end
  end

endmodule

// ==== mem_sys/bc_msg_gen.sv ====
module bc_msg_gen
  import riscv_block_pkg::*;
(
  input  logic                     clk,
  input  logic                     core_rst,
  input  logic [CORE_ID_WIDTH-1:0] core_id,

  core_mem_if.dst                  req,
  bc_msg_if.gen                    msg
);

  logic                    bc_store;
  logic                    spend;
  logic [CREDIT_WIDTH-1:0] credit_count;

  assign bc_store = req.req_valid && req.wen && (req.region == REGION_BC);

  ////////////////////////////////////////////////////////////////////////////
  // Message register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (core_rst) begin
      msg.msg_valid <= 1'b0;
    end else begin
      msg.msg_valid <= bc_store;
    end
  end

  always_ff @(posedge clk) begin
    if (bc_store) begin
      msg.msg[DATA_WIDTH-1:0]                     <= req.wr_data;
      msg.msg[MSG_OFFSET_LSB-1:MSG_STRB_LSB]      <= req.strb;
      msg.msg[MSG_CORE_ID_LSB-1:MSG_OFFSET_LSB]   <= req.word_addr[MSG_ADDR_WIDTH-1:0];
      msg.msg[MSG_WIDTH-1:MSG_CORE_ID_LSB]        <= core_id;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Credit counter
  ////////////////////////////////////////////////////////////////////////////

  // One credit per cycle of valid message
  assign spend = msg.msg_valid;

  always_ff @(posedge clk) begin
    if (core_rst) begin
      credit_count <= CREDIT_WIDTH'(BC_CREDITS);
    end else if (spend && !msg.credit) begin
      credit_count <= credit_count - 1'b1;
    end else if (msg.credit && !spend &&
                 (credit_count != CREDIT_WIDTH'(BC_CREDITS))) begin
      // Extra returns beyond the pool are dropped
      credit_count <= credit_count + 1'b1;
    end
  end

  assign msg.credits_free = credit_count;

endmodule

// ==== verilog/riscv_block.sv ====
module riscv_block
  import riscv_block_pkg::*;
(
  input  logic                       clk,
  input  logic                       core_rst,

  // Core data port
  input  logic                       core_mem_en,
  input  logic                       core_mem_wen,
  input  logic [STRB_WIDTH-1:0]      core_mem_strb,
  input  logic [CORE_ADDR_WIDTH-1:0] core_mem_addr,
  input  logic [DATA_WIDTH-1:0]      core_mem_wr_data,
  output logic                       core_mem_ready,
  output logic [DATA_WIDTH-1:0]      core_mem_rd_data,
  output logic                       core_mem_rd_valid,

  // Broadcast messages
  output logic [MSG_WIDTH-1:0]       bc_msg_out,
  output logic                       bc_msg_out_valid,
  input  logic                       bc_msg_credit,
  input  logic [MSG_WIDTH-1:0]       bc_msg_in,
  input  logic                       bc_msg_in_valid,

  // Status channel from the wrapper
  input  logic [STATUS_WIDTH-1:0]    wrapper_status_data,
  input  logic [1:0]                 wrapper_status_addr,
  input  logic                       wrapper_status_valid,
  output logic                       wrapper_status_ready,

  // Status channel to the wrapper
  output logic [STATUS_WIDTH-1:0]    core_status_data,
  output logic [1:0]                 core_status_addr,
  output logic                       core_status_valid
);

  core_mem_if req_if ();
  bc_msg_if   bc_if ();

  logic [CORE_ID_WIDTH-1:0] core_id;
  logic                     bc_enable;
  logic                     decode_error;

  ////////////////////////////////////////////////////////////////////////////
  // Status channels
  ////////////////////////////////////////////////////////////////////////////

  assign wrapper_status_ready = 1'b1;
  assign core_status_valid    = 1'b1;

  status_regs status_regs_i (
    .clk                  (clk),
    .core_rst             (core_rst),
    .wrapper_status_data  (wrapper_status_data),
    .wrapper_status_addr  (wrapper_status_addr),
    .wrapper_status_valid (wrapper_status_valid),
    .decode_error         (decode_error),
    .credits_free         (bc_if.credits_free),
    .core_id              (core_id),
    .bc_enable            (bc_enable),
    .core_status_data     (core_status_data),
    .core_status_addr     (core_status_addr)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Memory pipeline
  ////////////////////////////////////////////////////////////////////////////

  addr_decode addr_decode_i (
    .clk              (clk),
    .core_rst         (core_rst),
    .core_mem_en      (core_mem_en),
    .core_mem_wen     (core_mem_wen),
    .core_mem_strb    (core_mem_strb),
    .core_mem_addr    (core_mem_addr),
    .core_mem_wr_data (core_mem_wr_data),
    .credits_free     (bc_if.credits_free),
    .bc_enable        (bc_enable),
    .core_mem_ready   (core_mem_ready),
    .decode_error     (decode_error),
    .req              (req_if.src)
  );

  dmem_bank dmem_bank_i (
    .clk               (clk),
    .core_rst          (core_rst),
    .bc_msg_in         (bc_msg_in),
    .bc_msg_in_valid   (bc_msg_in_valid),
    .core_mem_rd_data  (core_mem_rd_data),
    .core_mem_rd_valid (core_mem_rd_valid),
    .req               (req_if.dst)
  );

  bc_msg_gen bc_msg_gen_i (
    .clk      (clk),
    .core_rst (core_rst),
    .core_id  (core_id),
    .req      (req_if.dst),
    .msg      (bc_if.gen)
  );

  // Outgoing broadcast channel
  assign bc_if.credit     = bc_msg_credit;
  assign bc_msg_out       = bc_if.msg;
  assign bc_msg_out_valid = bc_if.msg_valid;

endmodule

// ==== verification/riscv_block_checker.sv ====
module riscv_block_checker
  import riscv_block_pkg::*;
(
  input  logic                       clk,
  input  logic                       core_rst,
  input  logic                       core_mem_en,
  input  logic                       core_mem_wen,
  input  logic                       core_mem_ready,
  input  logic [CORE_ADDR_WIDTH-1:0] core_mem_addr,
  input  logic                       core_mem_rd_valid,
  input  logic                       bc_msg_out_valid,
  input  logic [STATUS_WIDTH-1:0]    core_status_data,
  input  logic [1:0]                 core_status_addr,
  input  logic                       core_status_valid,
  input  logic [STATUS_WIDTH-1:0]    wrapper_status_data,
  input  logic [1:0]                 wrapper_status_addr,
  input  logic                       wrapper_status_valid,
  input  logic                       wrapper_status_ready
);
  timeunit 1ns;
  timeprecision 1ps;

  int                      fail_count = 0;
  logic                    bc_en;
  logic                    accept;
  logic                    bc_accept;
  logic [CREDIT_WIDTH-1:0] credits;

  assign accept  = core_mem_en && core_mem_ready;
  assign credits = core_status_data[ERR_COUNT_WIDTH +: CREDIT_WIDTH];

  // Store into the broadcast region while broadcasting is on
  assign bc_accept = accept && core_mem_wen && bc_en &&
                     (core_mem_addr >= CORE_ADDR_WIDTH'(BC_BASE_WORD * 4)) &&
                     (core_mem_addr < CORE_ADDR_WIDTH'(DMEM_WORDS * 4));

  // Mirror of the broadcast enable, seen from the wrapper channel
  always_ff @(posedge clk) begin
    if (core_rst) begin
      bc_en <= 1'b1;
    end else if (wrapper_status_valid && (wrapper_status_addr == STAT_BC_ENABLE)) begin
      bc_en <= wrapper_status_data[0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Properties
  ////////////////////////////////////////////////////////////////////////////

  // An underflow wraps above the pool size, so one bound covers both ends
  credit_range_a: assert property (@(posedge clk) disable iff (core_rst)
    credits <= CREDIT_WIDTH'(BC_CREDITS))
  else begin
    $error("credit count outside 0 to BC_CREDITS");
    fail_count++;
  end

  msg_needs_credit_a: assert property (@(posedge clk) disable iff (core_rst)
    bc_msg_out_valid |-> (credits != '0))
  else begin
    $error("broadcast message sent with no free credit");
    fail_count++;
  end

  load_latency_a: assert property (@(posedge clk) disable iff (core_rst)
    (accept && !core_mem_wen) |-> ##2 core_mem_rd_valid)
  else begin
    $error("load data not returned two cycles after acceptance");
    fail_count++;
  end

  bc_latency_a: assert property (@(posedge clk) disable iff (core_rst)
    bc_accept |-> ##2 bc_msg_out_valid)
  else begin
    $error("no broadcast message two cycles after a broadcast store");
    fail_count++;
  end

  bc_origin_a: assert property (@(posedge clk) disable iff (core_rst)
    bc_msg_out_valid |-> $past(bc_accept, 2))
  else begin
    $error("broadcast message without a matching broadcast store");
    fail_count++;
  end

  // Fixed handshakes and status address on both status channels
  status_channel_a: assert property (@(posedge clk) disable iff (core_rst)
    wrapper_status_ready && core_status_valid && (core_status_addr == STAT_CORE_ID))
  else begin
    $error("status channel handshake or address not at its fixed value");
    fail_count++;
  end

endmodule

bind riscv_block riscv_block_checker checker_i (.*);

// ==== verification/riscv_block_tb.sv ====
module riscv_block_tb
  import riscv_block_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT  = 50;
  localparam int CLK_HALF = 10;

  logic                       clk;
  logic                       core_rst;
  logic                       core_mem_en;
  logic                       core_mem_wen;
  logic [STRB_WIDTH-1:0]      core_mem_strb;
  logic [CORE_ADDR_WIDTH-1:0] core_mem_addr;
  logic [DATA_WIDTH-1:0]      core_mem_wr_data;
  logic                       core_mem_ready;
  logic [DATA_WIDTH-1:0]      core_mem_rd_data;
  logic                       core_mem_rd_valid;
  logic [MSG_WIDTH-1:0]       bc_msg_out;
  logic                       bc_msg_out_valid;
  logic                       bc_msg_credit;
  logic [MSG_WIDTH-1:0]       bc_msg_in;
  logic                       bc_msg_in_valid;
  logic [STATUS_WIDTH-1:0]    wrapper_status_data;
  logic [1:0]                 wrapper_status_addr;
  logic                       wrapper_status_valid;
  logic                       wrapper_status_ready;
  logic [STATUS_WIDTH-1:0]    core_status_data;
  logic [1:0]                 core_status_addr;
  logic                       core_status_valid;

  // Expected memory contents
  logic [DATA_WIDTH-1:0] model [DMEM_WORDS];
  int                    seed;
  int                    errors;
  int                    checks;
  int                    tests;

  riscv_block dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [CORE_ADDR_WIDTH-1:0] byte_addr(input int word);
    return CORE_ADDR_WIDTH'(word * 4);
  endfunction

  function automatic logic [DATA_WIDTH-1:0] merge_bytes(input logic [DATA_WIDTH-1:0] old_word,
      input logic [DATA_WIDTH-1:0] new_word, input logic [STRB_WIDTH-1:0] strb);
    logic [DATA_WIDTH-1:0] result;
    result = old_word;
    for (int i = 0; i < STRB_WIDTH; i++) begin
      if (strb[i]) begin
        result[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return result;
  endfunction

  // Incoming message from another core, all bytes enabled
  function automatic logic [MSG_WIDTH-1:0] form_message(input int offset,
      input logic [DATA_WIDTH-1:0] data);
    return {CORE_ID_WIDTH'(3), MSG_ADDR_WIDTH'(offset), {STRB_WIDTH{1'b1}}, data};
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (act === exp)
    else begin
      errors++;
      $display("ERROR %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("Timeout, no %s within %0d cycles", what, TIMEOUT);
  endtask

  task automatic drive_request(input logic wen, input logic [STRB_WIDTH-1:0] strb,
      input logic [CORE_ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data);
    core_mem_en      = 1'b1;
    core_mem_wen     = wen;
    core_mem_strb    = strb;
    core_mem_addr    = addr;
    core_mem_wr_data = data;
  endtask

  // Hold the request until it is accepted, then drop it
  task automatic complete_request();
    int n;
    n = 0;
    while (!core_mem_ready && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!core_mem_ready) begin
      report_timeout("core_mem_ready");
    end
    @(negedge clk);
    core_mem_en = 1'b0;
  endtask

  task automatic issue_access(input logic wen, input logic [STRB_WIDTH-1:0] strb,
      input logic [CORE_ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data);
    drive_request(wen, strb, addr, data);
    complete_request();
  endtask

  task automatic load_word(input logic [CORE_ADDR_WIDTH-1:0] addr,
      output logic [DATA_WIDTH-1:0] data);
    int n;
    issue_access(1'b0, '0, addr, '0);
    n = 0;
    while (!core_mem_rd_valid && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!core_mem_rd_valid) begin
      report_timeout("core_mem_rd_valid");
    end
    data = core_mem_rd_data;
  endtask

  task automatic wait_message(output logic [MSG_WIDTH-1:0] msg);
    int n;
    n = 0;
    while (!bc_msg_out_valid && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!bc_msg_out_valid) begin
      report_timeout("bc_msg_out_valid");
    end
    msg = bc_msg_out;
  endtask

  task automatic expect_no_message(input string name, input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      checks++;
      assert (!bc_msg_out_valid)
      else begin
        errors++;
        $display("%s: a broadcast message went out when none was expected", name);
      end
    end
  endtask

  task automatic return_credit();
    bc_msg_credit = 1'b1;
    @(negedge clk);
    bc_msg_credit = 1'b0;
  endtask

  task automatic write_status(input status_addr_e addr, input logic [STATUS_WIDTH-1:0] data);
    wrapper_status_addr  = addr;
    wrapper_status_data  = data;
    wrapper_status_valid = 1'b1;
    @(negedge clk);
    wrapper_status_valid = 1'b0;
  endtask

  task automatic end_test(input string name, input int start);
    tests++;
    if (errors == start) begin
      $display("%s passed", name);
    end else begin
      $display("%s failed with %0d errors", name, errors - start);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [DATA_WIDTH-1:0]      data;
    logic [DATA_WIDTH-1:0]      rdata;
    logic [STRB_WIDTH-1:0]      strb;
    logic [MSG_WIDTH-1:0]       msg;
    logic [ERR_COUNT_WIDTH-1:0] err_before;
    int                         waddr;
    int                         start;
    seed                 = 32'he36b69d3;
    errors               = 0;
    checks               = 0;
    tests                = 0;
    core_rst             = 1'b1;
    core_mem_en          = 1'b0;
    core_mem_wen         = 1'b0;
    core_mem_strb        = '0;
    core_mem_addr        = '0;
    core_mem_wr_data     = '0;
    bc_msg_credit        = 1'b0;
    bc_msg_in            = '0;
    bc_msg_in_valid      = 1'b0;
    wrapper_status_data  = '0;
    wrapper_status_addr  = '0;
    wrapper_status_valid = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    core_rst = 1'b0;

    // Full word first, then a strobed overwrite
    start = errors;
    for (int i = 0; i < 12; i++) begin
      waddr = $unsigned($random(seed)) % BC_BASE_WORD;
      data  = $random(seed);
      issue_access(1'b1, '1, byte_addr(waddr), data);
      model[waddr] = data;
      data = $random(seed);
      strb = STRB_WIDTH'($random(seed));
      issue_access(1'b1, strb, byte_addr(waddr), data);
      model[waddr] = merge_bytes(model[waddr], data, strb);
      load_word(byte_addr(waddr), rdata);
      check_value("local_rw", 64'(model[waddr]), 64'(rdata));
    end
    end_test("local_rw", start);

    start = errors;
    write_status(STAT_CORE_ID, 32'h0000_0005);
    data = $random(seed);
    issue_access(1'b1, '1, byte_addr(BC_BASE_WORD + 5), data);
    model[BC_BASE_WORD + 5] = data;
    wait_message(msg);
    return_credit();
    check_value("bc_data", 64'(data), 64'(msg[DATA_WIDTH-1:0]));
    check_value("bc_strb", 64'(4'hf), 64'(msg[MSG_OFFSET_LSB-1:MSG_STRB_LSB]));
    check_value("bc_offset", 64'(5), 64'(msg[MSG_CORE_ID_LSB-1:MSG_OFFSET_LSB]));
    check_value("bc_core_id", 64'(5), 64'(msg[MSG_WIDTH-1:MSG_CORE_ID_LSB]));
    load_word(byte_addr(BC_BASE_WORD + 5), rdata);
    check_value("bc_local", 64'(model[BC_BASE_WORD + 5]), 64'(rdata));
    end_test("bc_store", start);

    // Drain the pool, then stall with one request waiting
    start = errors;
    check_value("credits_full", 64'(BC_CREDITS),
                64'(core_status_data[ERR_COUNT_WIDTH +: CREDIT_WIDTH]));
    for (int i = 0; i < BC_CREDITS; i++) begin
      data = $random(seed);
      issue_access(1'b1, '1, byte_addr(BC_BASE_WORD + 40 + i), data);
      model[BC_BASE_WORD + 40 + i] = data;
      wait_message(msg);
      check_value("credits_offset", 64'(40 + i), 64'(msg[MSG_CORE_ID_LSB-1:MSG_OFFSET_LSB]));
    end
    data = $random(seed);
    drive_request(1'b1, '1, byte_addr(BC_BASE_WORD + 44), data);
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      check_value("credits_stall", 64'(0), 64'(core_mem_ready));
      check_value("credits_no_msg", 64'(0), 64'(bc_msg_out_valid));
    end
    check_value("credits_empty", 64'(0),
                64'(core_status_data[ERR_COUNT_WIDTH +: CREDIT_WIDTH]));
    return_credit();
    complete_request();
    model[BC_BASE_WORD + 44] = data;
    wait_message(msg);
    check_value("credits_release", 64'(44), 64'(msg[MSG_CORE_ID_LSB-1:MSG_OFFSET_LSB]));
    @(negedge clk);
    check_value("credits_stall_again", 64'(0), 64'(core_mem_ready));
    // One return more than the pool holds, which must be dropped
    repeat (BC_CREDITS + 1) return_credit();
    check_value("credits_restored", 64'(BC_CREDITS),
                64'(core_status_data[ERR_COUNT_WIDTH +: CREDIT_WIDTH]));
    end_test("credits", start);

    start = errors;
    data = $random(seed);
    bc_msg_in       = form_message(10, data);
    bc_msg_in_valid = 1'b1;
    @(negedge clk);
    bc_msg_in_valid = 1'b0;
    model[BC_BASE_WORD + 10] = data;
    load_word(byte_addr(BC_BASE_WORD + 10), rdata);
    check_value("bc_in_word", 64'(model[BC_BASE_WORD + 10]), 64'(rdata));
    // Core store and incoming word hit the same word in one cycle
    data = $random(seed);
    issue_access(1'b1, '1, byte_addr(BC_BASE_WORD + 20), data);
    data = $random(seed);
    bc_msg_in       = form_message(20, data);
    bc_msg_in_valid = 1'b1;
    @(negedge clk);
    bc_msg_in_valid = 1'b0;
    model[BC_BASE_WORD + 20] = data;
    wait_message(msg);
    return_credit();
    load_word(byte_addr(BC_BASE_WORD + 20), rdata);
    check_value("bc_in_collision", 64'(model[BC_BASE_WORD + 20]), 64'(rdata));
    end_test("bc_incoming", start);

    start = errors;
    write_status(STAT_BC_ENABLE, 32'h0);
    data = $random(seed);
    issue_access(1'b1, '1, byte_addr(BC_BASE_WORD + 30), data);
    model[BC_BASE_WORD + 30] = data;
    expect_no_message("bc_disabled", 4);
    load_word(byte_addr(BC_BASE_WORD + 30), rdata);
    check_value("bc_disabled_local", 64'(model[BC_BASE_WORD + 30]), 64'(rdata));
    err_before = core_status_data[ERR_COUNT_WIDTH-1:0];
    load_word(byte_addr(DMEM_WORDS), rdata);
    check_value("invalid_data", 64'(0), 64'(rdata));
    check_value("invalid_err_count", 64'(err_before + 1'b1),
                64'(core_status_data[ERR_COUNT_WIDTH-1:0]));
    write_status(STAT_BC_ENABLE, 32'h1);
    end_test("disabled_invalid", start);

    repeat (4) @(negedge clk);
    $display("Tests %0d, checks %0d, errors %0d, assertion failures %0d",
             tests, checks, errors, dut_i.checker_i.fail_count);
    if ((errors == 0) && (dut_i.checker_i.fail_count == 0)) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
common/riscv_block_pkg.sv
common/core_mem_if.sv
common/bc_msg_if.sv
verilog/status_regs.sv
mem_sys/addr_decode.sv
mem_sys/dmem_bank.sv
mem_sys/bc_msg_gen.sv
verilog/riscv_block.sv
verification/riscv_block_checker.sv
verification/riscv_block_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= riscv_block_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert --timescale $(TIMESCALE) \
		--top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
